/* files.f */
design/ext_mem_pkg.sv
design/store_fifo.sv
design/tag_store_queue.sv
design/store_router.sv
design/mem_write_arbiter.sv
design/ext_mem_array.sv
design/error_monitor.sv
design/ext_memory_top.sv
tests/tb_ext_memory.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f files.f \
  --top-module tb_ext_memory --Mdir obj_dir -o tb_ext_memory &&
./obj_dir/tb_ext_memory | tee /dev/stderr | grep -q "TESTS PASSED" &&
echo "Simulation run succeeded" ||
{ echo "Simulation run did not pass"; exit 1; }

/* tests/tb_ext_memory.sv */
// Testbench for the external memory port
// Table of load, store, back-pressure and error rows applied in a loop
// Reference memory model and typed compare tasks
`timescale 1ns/1ps
`default_nettype none

module tb_ext_memory
  import ext_mem_pkg::*;
();

  localparam int WAIT_LIMIT = 20;
  localparam int ERR_LIMIT  = DEADLOCK_TIMEOUT + 8;

  typedef enum int {
    OP_STORE,
    OP_LOAD,
    OP_STALL,
    OP_FULL,
    OP_DRAIN,
    OP_PAIR2,
    OP_ADDR_ONLY,
    OP_ERR_WAIT,
    OP_RESET
  } op_t;

  // One row of stimulus; expected tag of a store is its request tag
  typedef struct packed {
    op_t         op;
    int          a_port;
    int          d_port;
    tag_t        tag;
    addr_t       addr;
    word_t       data;
    word_t       data2;
    logic [15:0] exp_code;
  } row_t;

  logic                  clk;
  logic                  rst_n;
  mem_req_t [NUM_LD-1:0] ld_req;
  logic     [NUM_LD-1:0] ld_req_valid;
  logic     [NUM_LD-1:0] ld_req_ready;
  mem_rsp_t [NUM_LD-1:0] ld_rsp;
  logic     [NUM_LD-1:0] ld_rsp_valid;
  logic     [NUM_LD-1:0] ld_rsp_ready;
  mem_rsp_t              ld_done;
  logic                  ld_done_valid;
  logic                  ld_done_ready;
  mem_req_t [NUM_ST-1:0] st_addr;
  logic     [NUM_ST-1:0] st_addr_valid;
  logic     [NUM_ST-1:0] st_addr_ready;
  st_data_t [NUM_ST-1:0] st_data;
  logic     [NUM_ST-1:0] st_data_valid;
  logic     [NUM_ST-1:0] st_data_ready;
  mem_rsp_t              st_done;
  logic                  st_done_valid;
  logic                  st_done_ready;
  logic                  error_valid;
  logic     [15:0]       error_code;

  int    seed;
  int    errors;
  int    timeouts;
  int    rr_last;
  word_t ref_mem [MEM_DEPTH];
  row_t  rows[$];
  row_t  pending[$];

  ext_memory_top DUT (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // --------------------
  // Compare tasks
  // --------------------
  task automatic check_rsp(input string name, input mem_rsp_t got, input mem_rsp_t exp);
    if (got !== exp) begin
      errors++;
      $display("Fail %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_err(input logic [15:0] got, input logic [15:0] exp);
    if (got !== exp) begin
      errors++;
      $display("Fail error_code: got %h expected %h", got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      errors++;
      $display("Fail %s: got %h expected %h", name, got, exp);
    end
  endtask

  // --------------------
  // Stream helpers
  // --------------------
  // Holds each valid until its own handshake, ends on the falling edge after the last
  task automatic send_ports(input logic [NUM_ST-1:0] av, input logic [NUM_ST-1:0] dv);
    logic [NUM_ST-1:0] a_pend;
    logic [NUM_ST-1:0] d_pend;
    int                n;
    a_pend = av;
    d_pend = dv;
    n      = 0;
    while ((a_pend != '0 || d_pend != '0) && n < WAIT_LIMIT) begin
      st_addr_valid = a_pend;
      st_data_valid = d_pend;
      #1;
      a_pend = a_pend & ~st_addr_ready;
      d_pend = d_pend & ~st_data_ready;
      @(negedge clk);
      n++;
    end
    st_addr_valid = '0;
    st_data_valid = '0;
    if (a_pend != '0 || d_pend != '0) begin
      timeouts++;
      $display("Timeout: store ports never became ready");
    end
  endtask

  task automatic wait_done(output mem_rsp_t got);
    int n;
    n = 0;
    #1;
    while (!st_done_valid && n < WAIT_LIMIT) begin
      @(negedge clk);
      #1;
      n++;
    end
    got = st_done;
    if (!st_done_valid) begin
      timeouts++;
      $display("Timeout: no store completion reported");
    end
    @(negedge clk);
  endtask

  task automatic load_check(input int port, input tag_t tag, input addr_t addr);
    int n;
    n                  = 0;
    ld_req[port]       = '{tag: tag, addr: addr};
    ld_req_valid[port] = 1'b1;
    #1;
    while (!ld_req_ready[port] && n < WAIT_LIMIT) begin
      @(negedge clk);
      #1;
      n++;
    end
    if (!ld_req_ready[port]) begin
      timeouts++;
      $display("Timeout: load port %0d never became ready", port);
    end
    check_flag("ld_rsp_valid", ld_rsp_valid[port], 1'b1);
    check_rsp("ld_rsp", ld_rsp[port], mem_rsp_t'{tag: tag, data: ref_mem[addr]});
    check_flag("ld_done_valid", ld_done_valid, 1'b1);
    check_rsp("ld_done", ld_done, mem_rsp_t'{tag: tag, data: '0});
    @(negedge clk);
    ld_req_valid[port] = 1'b0;
  endtask

  task automatic wait_error(input logic [15:0] exp);
    int n;
    n = 0;
    #1;
    while (!error_valid && n < ERR_LIMIT) begin
      @(negedge clk);
      #1;
      n++;
    end
    if (!error_valid) begin
      timeouts++;
      $display("Timeout: error_valid never rose");
    end else begin
      check_err(error_code, exp);
    end
  endtask

  task automatic apply_reset();
    rst_n = 1'b0;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
  endtask

  // --------------------
  // Table
  // --------------------
  function automatic void add_row(input op_t op, input int a_port, input int d_port,
                                  input tag_t tag, input addr_t addr,
                                  input logic [15:0] exp_code);
    row_t r;
    r.op       = op;
    r.a_port   = a_port;
    r.d_port   = d_port;
    r.tag      = tag;
    r.addr     = addr;
    r.data     = $random(seed);
    r.data2    = $random(seed);
    r.exp_code = exp_code;
    rows.push_back(r);
  endfunction

  function automatic void build_table();
    add_row(OP_STORE,     0, 0, 2'd0, 8'h10, 16'h0);
    add_row(OP_LOAD,      0, 0, 2'd0, 8'h10, 16'h0);
    add_row(OP_LOAD,      1, 0, 2'd1, 8'h10, 16'h0);
    // Address and data of tag 1 on different ports
    add_row(OP_STORE,     0, 1, 2'd1, 8'h20, 16'h0);
    add_row(OP_LOAD,      0, 0, 2'd1, 8'h20, 16'h0);
    // Back-pressure, same address twice to expose write order
    add_row(OP_STALL,     0, 0, 2'd0, 8'h10, 16'h0);
    add_row(OP_STALL,     0, 0, 2'd0, 8'h30, 16'h0);
    add_row(OP_STALL,     0, 0, 2'd0, 8'h31, 16'h0);
    add_row(OP_STALL,     0, 0, 2'd0, 8'h10, 16'h0);
    add_row(OP_FULL,      0, 0, 2'd0, 8'h32, 16'h0);
    add_row(OP_LOAD,      1, 0, 2'd0, 8'h10, 16'h0);
    add_row(OP_DRAIN,     0, 0, 2'd0, 8'h00, 16'h0);
    add_row(OP_LOAD,      0, 0, 2'd0, 8'h10, 16'h0);
    add_row(OP_LOAD,      1, 0, 2'd1, 8'h31, 16'h0);
    add_row(OP_PAIR2,     0, 0, 2'd0, 8'h40, 16'h0);
    add_row(OP_LOAD,      0, 0, 2'd0, 8'h40, 16'h0);
    add_row(OP_LOAD,      1, 0, 2'd1, 8'h41, 16'h0);
    // Load tag out of range, then traffic while the error holds
    add_row(OP_LOAD,      0, 0, 2'd2, 8'h20, 16'h0);
    add_row(OP_ERR_WAIT,  0, 0, 2'd0, 8'h00, ERR_TAG_OOB);
    add_row(OP_STORE,     1, 1, 2'd1, 8'h50, 16'h0);
    add_row(OP_LOAD,      1, 0, 2'd1, 8'h50, 16'h0);
    add_row(OP_ERR_WAIT,  0, 0, 2'd0, 8'h00, ERR_TAG_OOB);
    add_row(OP_RESET,     0, 0, 2'd0, 8'h00, 16'h0);
    add_row(OP_ADDR_ONLY, 0, 0, 2'd1, 8'h60, 16'h0);
    add_row(OP_ERR_WAIT,  0, 0, 2'd0, 8'h00, ERR_STORE_DEADLOCK);
  endfunction

  task automatic apply_row(input row_t r);
    mem_rsp_t got;
    row_t     p;
    tag_t     first;
    case (r.op)
      OP_STORE: begin
        st_addr[r.a_port] = '{tag: r.tag, addr: r.addr};
        st_data[r.d_port] = '{tag: r.tag, data: r.data};
        send_ports(NUM_ST'(1) << r.a_port, NUM_ST'(1) << r.d_port);
        wait_done(got);
        check_rsp("st_done", got, mem_rsp_t'{tag: r.tag, data: '0});
        ref_mem[r.addr] = r.data;
        rr_last         = int'(r.tag);
      end
      OP_LOAD: begin
        if (int'(r.tag) >= NUM_LD) begin
          check_flag("error_valid", error_valid, 1'b0);
        end
        load_check(r.a_port, r.tag, r.addr);
      end
      OP_STALL: begin
        st_done_ready     = 1'b0;
        st_addr[r.a_port] = '{tag: r.tag, addr: r.addr};
        st_data[r.d_port] = '{tag: r.tag, data: r.data};
        send_ports(NUM_ST'(1) << r.a_port, NUM_ST'(1) << r.d_port);
        pending.push_back(r);
      end
      OP_FULL: begin
        st_addr[r.a_port] = '{tag: r.tag, addr: r.addr};
        st_data[r.d_port] = '{tag: r.tag, data: r.data};
        #1;
        check_flag("st_addr_ready", st_addr_ready[r.a_port], 1'b0);
        check_flag("st_data_ready", st_data_ready[r.d_port], 1'b0);
        check_flag("st_done_valid", st_done_valid, 1'b1);
      end
      OP_DRAIN: begin
        st_done_ready = 1'b1;
        while (pending.size() > 0) begin
          p = pending.pop_front();
          wait_done(got);
          check_rsp("st_done", got, mem_rsp_t'{tag: p.tag, data: '0});
          ref_mem[p.addr] = p.data;
          rr_last         = int'(p.tag);
        end
      end
      OP_PAIR2: begin
        st_addr[0] = '{tag: tag_t'(0), addr: r.addr};
        st_addr[1] = '{tag: tag_t'(1), addr: addr_t'(r.addr + 1'b1)};
        st_data[0] = '{tag: tag_t'(0), data: r.data};
        st_data[1] = '{tag: tag_t'(1), data: r.data2};
        send_ports('1, '1);
        // The tag granted last has the lowest priority
        first = tag_t'((rr_last + 1) % NUM_ST);
        wait_done(got);
        check_rsp("st_done", got, mem_rsp_t'{tag: first, data: '0});
        wait_done(got);
        check_rsp("st_done", got, mem_rsp_t'{tag: tag_t'((int'(first) + 1) % NUM_ST), data: '0});
        rr_last                          = (int'(first) + 1) % NUM_ST;
        ref_mem[r.addr]                  = r.data;
        ref_mem[addr_t'(r.addr + 1'b1)] = r.data2;
      end
      OP_ADDR_ONLY: begin
        st_addr[r.a_port] = '{tag: r.tag, addr: r.addr};
        send_ports(NUM_ST'(1) << r.a_port, '0);
      end
      OP_ERR_WAIT: begin
        wait_error(r.exp_code);
      end
      default: begin
        apply_reset();
        #1;
        check_flag("error_valid", error_valid, 1'b0);
        check_flag("st_done_valid", st_done_valid, 1'b0);
        check_flag("ld_done_valid", ld_done_valid, 1'b0);
      end
    endcase
  endtask

  // --------------------
  // Main sequence
  // --------------------
  initial begin
    seed          = 32'hc637_60a6;
    errors        = 0;
    timeouts      = 0;
    rr_last       = 0;
    ld_req        = '0;
    ld_req_valid  = '0;
    ld_rsp_ready  = '1;
    ld_done_ready = 1'b1;
    st_addr       = '0;
    st_addr_valid = '0;
    st_data       = '0;
    st_data_valid = '0;
    st_done_ready = 1'b1;
    build_table();
    apply_reset();
    foreach (rows[i]) begin
      @(negedge clk);
      apply_row(rows[i]);
    end
    repeat (2) @(negedge clk);
    $display("Checks done: %0d value errors, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* design/ext_memory_top.sv */
// External memory port top level
// Load ports and ld_done, tag-routed store path, write arbiter, memory, errors
`timescale 1ns/1ps
`default_nettype none

module ext_memory_top
  import ext_mem_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  // Loads
  input  mem_req_t [NUM_LD-1:0] ld_req,
  input  logic     [NUM_LD-1:0] ld_req_valid,
  output logic     [NUM_LD-1:0] ld_req_ready,
  output mem_rsp_t [NUM_LD-1:0] ld_rsp,
  output logic     [NUM_LD-1:0] ld_rsp_valid,
  input  logic     [NUM_LD-1:0] ld_rsp_ready,
  output mem_rsp_t              ld_done,
  output logic                  ld_done_valid,
  input  logic                  ld_done_ready,
  // Stores
  input  mem_req_t [NUM_ST-1:0] st_addr,
  input  logic     [NUM_ST-1:0] st_addr_valid,
  output logic     [NUM_ST-1:0] st_addr_ready,
  input  st_data_t [NUM_ST-1:0] st_data,
  input  logic     [NUM_ST-1:0] st_data_valid,
  output logic     [NUM_ST-1:0] st_data_ready,
  output mem_rsp_t              st_done,
  output logic                  st_done_valid,
  input  logic                  st_done_ready,
  // Errors
  output logic                  error_valid,
  output logic     [15:0]       error_code
);

  logic     [NUM_ST-1:0] addr_push;
  addr_t    [NUM_ST-1:0] addr_val;
  logic     [NUM_ST-1:0] data_push;
  word_t    [NUM_ST-1:0] data_val;
  logic     [NUM_ST-1:0] addr_full;
  logic     [NUM_ST-1:0] data_full;
  logic     [NUM_ST-1:0] pair_req;
  st_pair_t [NUM_ST-1:0] pair;
  logic     [NUM_ST-1:0] pop;
  logic     [NUM_ST-1:0] deadlock_hit;
  logic                  wr_en;
  addr_t                 wr_addr;
  word_t                 wr_data;
  addr_t    [NUM_LD-1:0] rd_addr;
  word_t    [NUM_LD-1:0] rd_data;

  // --------------------
  // Load path
  // --------------------
  for (genvar i = 0; i < NUM_LD; i++) begin : g_load
    assign rd_addr[i] = ld_req[i].addr;
    assign ld_rsp[i]  = '{tag: ld_req[i].tag, data: rd_data[i]};
  end

  assign ld_rsp_valid = ld_req_valid;
  // A load completes only when both result and done streams take it
  assign ld_req_ready = ld_rsp_ready & {NUM_LD{ld_done_ready}};

  // Highest-numbered valid port reports its tag
  always_comb begin : ld_done_select
    ld_done = '0;
    for (int i = 0; i < NUM_LD; i++) begin
      if (ld_req_valid[i]) begin
        ld_done.tag = ld_req[i].tag;
      end
    end
  end

  assign ld_done_valid = |ld_req_valid;

  // --------------------
  // Store path
  // --------------------
  store_router u_router (
    .st_addr       (st_addr),
    .st_addr_valid (st_addr_valid),
    .st_addr_ready (st_addr_ready),
    .st_data       (st_data),
    .st_data_valid (st_data_valid),
    .st_data_ready (st_data_ready),
    .addr_full     (addr_full),
    .data_full     (data_full),
    .addr_push     (addr_push),
    .addr_val      (addr_val),
    .data_push     (data_push),
    .data_val      (data_val)
  );

  for (genvar t = 0; t < NUM_ST; t++) begin : g_tag
    tag_store_queue u_queue (
      .clk          (clk),
      .rst_n        (rst_n),
      .addr_push    (addr_push[t]),
      .addr_in      (addr_val[t]),
      .data_push    (data_push[t]),
      .data_in      (data_val[t]),
      .pop          (pop[t]),
      .addr_full    (addr_full[t]),
      .data_full    (data_full[t]),
      .pair_req     (pair_req[t]),
      .pair         (pair[t]),
      .deadlock_hit (deadlock_hit[t])
    );
  end

  mem_write_arbiter u_arbiter (
    .clk           (clk),
    .rst_n         (rst_n),
    .pair_req      (pair_req),
    .pair          (pair),
    .pop           (pop),
    .wr_en         (wr_en),
    .wr_addr       (wr_addr),
    .wr_data       (wr_data),
    .st_done       (st_done),
    .st_done_valid (st_done_valid),
    .st_done_ready (st_done_ready)
  );

  ext_mem_array u_mem (
    .clk     (clk),
    .rd_addr (rd_addr),
    .rd_data (rd_data),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data)
  );

  // --------------------
  // Errors
  // --------------------
  error_monitor u_errors (
    .clk           (clk),
    .rst_n         (rst_n),
    .ld_req        (ld_req),
    .ld_req_valid  (ld_req_valid),
    .st_addr       (st_addr),
    .st_addr_valid (st_addr_valid),
    .st_data       (st_data),
    .st_data_valid (st_data_valid),
    .deadlock_hit  (deadlock_hit),
    .error_valid   (error_valid),
    .error_code    (error_code)
  );

endmodule

`default_nettype wire

/* design/error_monitor.sv */
// Tag range checks on load and store requests, deadlock collection
// First-error latch held until reset
`timescale 1ns/1ps
`default_nettype none

module error_monitor
  import ext_mem_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  mem_req_t [NUM_LD-1:0] ld_req,
  input  logic     [NUM_LD-1:0] ld_req_valid,
  input  mem_req_t [NUM_ST-1:0] st_addr,
  input  logic     [NUM_ST-1:0] st_addr_valid,
  input  st_data_t [NUM_ST-1:0] st_data,
  input  logic     [NUM_ST-1:0] st_data_valid,
  input  logic     [NUM_ST-1:0] deadlock_hit,
  output logic                  error_valid,
  output logic     [15:0]       error_code
);

  logic        tag_oob;
  logic        err_detect;
  logic [15:0] err_code_next;

  // Only valid requests count
  always_comb begin : oob_check
    tag_oob = 1'b0;
    for (int i = 0; i < NUM_LD; i++) begin
      if (ld_req_valid[i] && int'(ld_req[i].tag) >= NUM_LD) begin
        tag_oob = 1'b1;
      end
    end
    for (int i = 0; i < NUM_ST; i++) begin
      if (st_addr_valid[i] && int'(st_addr[i].tag) >= NUM_ST) begin
        tag_oob = 1'b1;
      end
      if (st_data_valid[i] && int'(st_data[i].tag) >= NUM_ST) begin
        tag_oob = 1'b1;
      end
    end
  end

  // Range error outranks deadlock
  assign err_detect    = tag_oob || (|deadlock_hit);
  assign err_code_next = tag_oob ? ERR_TAG_OOB : ERR_STORE_DEADLOCK;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      error_valid <= 1'b0;
      error_code  <= '0;
    end else if (!error_valid && err_detect) begin
      error_valid <= 1'b1;
      error_code  <= err_code_next;
    end
  end

endmodule

`default_nettype wire

/* design/ext_mem_array.sv */
// Behavioral 256-word memory
// Combinational read per load port and one clocked write port
`timescale 1ns/1ps
`default_nettype none

module ext_mem_array
  import ext_mem_pkg::*;
(
  input  logic               clk,
  input  addr_t [NUM_LD-1:0] rd_addr,
  output word_t [NUM_LD-1:0] rd_data,
  input  logic               wr_en,
  input  addr_t              wr_addr,
  input  word_t              wr_data
);

  word_t mem [MEM_DEPTH];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Reads see the old word during a same-cycle write
  for (genvar i = 0; i < NUM_LD; i++) begin : g_rd
    assign rd_data[i] = mem[rd_addr[i]];
  end

endmodule

`default_nettype wire

/* design/mem_write_arbiter.sv */
// Round-robin choice of one paired tag for the single write port
// Memory write strobe and the store-done stream from the same grant
`timescale 1ns/1ps
`default_nettype none

module mem_write_arbiter
  import ext_mem_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic     [NUM_ST-1:0] pair_req,
  input  st_pair_t [NUM_ST-1:0] pair,
  output logic     [NUM_ST-1:0] pop,
  output logic                  wr_en,
  output addr_t                 wr_addr,
  output word_t                 wr_data,
  output mem_rsp_t              st_done,
  output logic                  st_done_valid,
  input  logic                  st_done_ready
);

  logic [ST_IDX_W-1:0] last_grant;
  logic [ST_IDX_W-1:0] sel;

  // Search starts just after the last granted tag
  always_comb begin : rr_select
    int   idx;
    logic found;
    sel   = last_grant;
    found = 1'b0;
    for (int i = 1; i <= NUM_ST; i++) begin
      idx = (int'(last_grant) + i) % NUM_ST;
      if (!found && pair_req[idx]) begin
        sel   = ST_IDX_W'(idx);
        found = 1'b1;
      end
    end
  end

  assign st_done_valid = |pair_req;
  assign st_done       = '{tag: tag_t'(sel), data: '0};

  // Grant is the st_done handshake
  assign wr_en   = st_done_valid && st_done_ready;
  assign wr_addr = pair[sel].addr;
  assign wr_data = pair[sel].data;
  assign pop     = wr_en ? (NUM_ST'(1) << sel) : '0;

  // Tag 0 wins the first grant after reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      last_grant <= ST_IDX_W'(NUM_ST - 1);
    end else if (wr_en) begin
      last_grant <= sel;
    end
  end

  // A pending pair cannot vanish while st_done is stalled
  a_done_held: assert property (@(posedge clk) disable iff (!rst_n)
    st_done_valid && !st_done_ready |=> st_done_valid)
    else $error("mem_write_arbiter dropped st_done while stalled");

endmodule

`default_nettype wire

/* design/store_router.sv */
// Steering of store address and store data ports to per-tag queues
// Tag clamping and a single grant per tag and kind in each cycle
`timescale 1ns/1ps
`default_nettype none

module store_router
  import ext_mem_pkg::*;
(
  input  mem_req_t [NUM_ST-1:0] st_addr,
  input  logic     [NUM_ST-1:0] st_addr_valid,
  output logic     [NUM_ST-1:0] st_addr_ready,
  input  st_data_t [NUM_ST-1:0] st_data,
  input  logic     [NUM_ST-1:0] st_data_valid,
  output logic     [NUM_ST-1:0] st_data_ready,
  input  logic     [NUM_ST-1:0] addr_full,
  input  logic     [NUM_ST-1:0] data_full,
  output logic     [NUM_ST-1:0] addr_push,
  output addr_t    [NUM_ST-1:0] addr_val,
  output logic     [NUM_ST-1:0] data_push,
  output word_t    [NUM_ST-1:0] data_val
);

  // Out-of-range tags land on tag 0; the error monitor flags them
  function automatic int target_tag(input tag_t tag);
    return (int'(tag) >= NUM_ST) ? 0 : int'(tag);
  endfunction

  // A push already issued to a tag blocks higher ports for that tag
  always_comb begin : route_addr
    int tgt;
    addr_push     = '0;
    addr_val      = '0;
    st_addr_ready = '0;
    for (int p = 0; p < NUM_ST; p++) begin
      tgt = target_tag(st_addr[p].tag);
      if (!addr_full[tgt] && !addr_push[tgt]) begin
        st_addr_ready[p] = 1'b1;
        if (st_addr_valid[p]) begin
          addr_push[tgt] = 1'b1;
          addr_val[tgt]  = st_addr[p].addr;
        end
      end
    end
  end

  always_comb begin : route_data
    int tgt;
    data_push     = '0;
    data_val      = '0;
    st_data_ready = '0;
    for (int p = 0; p < NUM_ST; p++) begin
      tgt = target_tag(st_data[p].tag);
      if (!data_full[tgt] && !data_push[tgt]) begin
        st_data_ready[p] = 1'b1;
        if (st_data_valid[p]) begin
          data_push[tgt] = 1'b1;
          data_val[tgt]  = st_data[p].data;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* design/tag_store_queue.sv */
// Pending store halves of one tag: address queue and data queue
// Pair request toward the write arbiter and the unpaired stall timer
`timescale 1ns/1ps
`default_nettype none

module tag_store_queue
  import ext_mem_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     addr_push,
  input  addr_t    addr_in,
  input  logic     data_push,
  input  word_t    data_in,
  input  logic     pop,
  output logic     addr_full,
  output logic     data_full,
  output logic     pair_req,
  output st_pair_t pair,
  output logic     deadlock_hit
);

  logic               addr_empty;
  logic               data_empty;
  addr_t              addr_head;
  word_t              data_head;
  logic               one_sided;
  logic [STALL_W-1:0] stall_cnt;

  store_fifo #(.item_t(addr_t)) u_addr_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (addr_push),
    .push_item (addr_in),
    .pop       (pop),
    .head      (addr_head),
    .empty     (addr_empty),
    .full      (addr_full)
  );

  store_fifo #(.item_t(word_t)) u_data_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (data_push),
    .push_item (data_in),
    .pop       (pop),
    .head      (data_head),
    .empty     (data_empty),
    .full      (data_full)
  );

  assign pair_req = !addr_empty && !data_empty;
  assign pair     = '{addr: addr_head, data: data_head};

  // Stall timer runs only while one half waits for the other
  assign one_sided = addr_empty ^ data_empty;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stall_cnt <= '0;
    end else if (!one_sided) begin
      stall_cnt <= '0;
    end else if (stall_cnt != STALL_W'(DEADLOCK_TIMEOUT)) begin
      stall_cnt <= stall_cnt + 1'b1;
    end
  end

  assign deadlock_hit = (stall_cnt == STALL_W'(DEADLOCK_TIMEOUT));

  // Arbiter only dequeues a complete pair
  a_pop_paired: assert property (@(posedge clk) disable iff (!rst_n) pop |-> pair_req)
    else $error("tag_store_queue pop without a pair");

endmodule

`default_nettype wire

/* design/store_fifo.sv */
// Circular queue of LSQ_DEPTH entries with an occupancy count
// Payload type chosen per instance
`timescale 1ns/1ps
`default_nettype none

module store_fifo
  import ext_mem_pkg::*;
#(
  parameter type item_t = word_t
) (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  push,
  input  item_t push_item,
  input  logic  pop,
  output item_t head,
  output logic  empty,
  output logic  full
);

  item_t                mem [LSQ_DEPTH];
  logic [LSQ_PTR_W-1:0] wr_ptr;
  logic [LSQ_PTR_W-1:0] rd_ptr;
  logic [LSQ_CNT_W-1:0] count;

  function automatic logic [LSQ_PTR_W-1:0] next_ptr(input logic [LSQ_PTR_W-1:0] ptr);
    return (ptr == LSQ_PTR_W'(LSQ_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign empty = (count == '0);
  assign full  = (count == LSQ_CNT_W'(LSQ_DEPTH));
  assign head  = mem[rd_ptr];

  // Storage has no reset
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_item;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      // Push and pop together leave the count alone
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Router must respect full, arbiter must respect empty
  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n) push |-> !full)
    else $error("store_fifo push while full");
  a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n) pop |-> !empty)
    else $error("store_fifo pop while empty");

endmodule

`default_nettype wire

/* design/ext_mem_pkg.sv */
// Shared sizes, counter widths and error codes of the external memory port
// Field typedefs and the request, store data, pair and response structs
`default_nettype none

package ext_mem_pkg;

  // --------------------
  // Sizes and counts
  // --------------------
  localparam int DATA_W           = 32;
  localparam int MEM_DEPTH        = 256;
  localparam int ADDR_W           = $clog2(MEM_DEPTH);
  localparam int TAG_W            = 2;
  localparam int NUM_LD           = 2;
  // One tag per store port
  localparam int NUM_ST           = 2;
  localparam int LSQ_DEPTH        = 4;
  localparam int DEADLOCK_TIMEOUT = 64;

  // Counter and index widths
  localparam int LSQ_PTR_W = (LSQ_DEPTH > 1) ? $clog2(LSQ_DEPTH) : 1;
  localparam int LSQ_CNT_W = $clog2(LSQ_DEPTH + 1);
  localparam int STALL_W   = $clog2(DEADLOCK_TIMEOUT + 1);
  localparam int ST_IDX_W  = (NUM_ST > 1) ? $clog2(NUM_ST) : 1;

  // Error codes
  localparam logic [15:0] ERR_TAG_OOB        = 16'h0001;
  localparam logic [15:0] ERR_STORE_DEADLOCK = 16'h0002;

  // --------------------
  // Types
  // --------------------
  typedef logic [TAG_W-1:0]  tag_t;
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] word_t;

  // Load request or store address
  typedef struct packed {
    tag_t  tag;
    addr_t addr;
  } mem_req_t;

  typedef struct packed {
    tag_t  tag;
    word_t data;
  } st_data_t;

  // Load result, or a done token with data left at zero
  typedef struct packed {
    tag_t  tag;
    word_t data;
  } mem_rsp_t;

  // Head address and head word of one tag, ready to be written
  typedef struct packed {
    addr_t addr;
    word_t data;
  } st_pair_t;

endpackage

`default_nettype wire
